// File: fetch_golden.txt
// act rdata valid err | ex valid kind taken mispredict pc target history | ras push data
// expected pc inst trap{misaligned,fault} stall pdt_taken history next_pc_valid next_pc
// reset pc, sequential fetch, return address pushed from ID
1_00000013_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000000_00000013_0_0_0_00_0_80000004
1_00000013_1_0_0_0_0_0_00000000_00000000_00_1_80000100_80000004_00000013_0_0_0_00_0_80000008
// return under stall keeps the ras entry, then pops it
1_00008067_0_0_0_0_0_0_00000000_00000000_00_0_00000000_80000008_00008067_0_1_1_00_1_80000100
1_00008067_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000008_00008067_0_0_1_00_1_80000100
1_00008067_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000100_00008067_0_0_0_00_0_80000104
// jalr misses the btb, is resolved, then hits
1_00028067_1_0_1_2_1_1_80000104_80000200_00_0_00000000_80000104_00028067_0_0_0_00_0_80000108
1_00000013_1_0_1_1_1_1_80000200_80000104_00_0_00000000_80000200_00000013_0_0_0_00_0_80000204
1_00028067_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000104_00028067_0_0_1_00_1_80000200
// jal, then a backward branch learned through the gshare hash
1_0100006f_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000200_0100006f_0_0_1_00_1_80000210
1_fe000ce3_1_0_1_3_1_1_80000210_80000208_00_0_00000000_80000210_fe000ce3_0_0_0_00_0_80000214
1_0080006f_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000208_0080006f_0_0_1_01_1_80000210
1_fe000ce3_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000210_fe000ce3_0_0_0_01_0_80000214
1_fe000ce3_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000214_fe000ce3_0_0_1_01_1_8000020c
// not-taken redirect lands during a stall
1_00000013_0_0_1_3_0_1_80000214_8000020c_01_0_00000000_8000020c_00000013_0_1_0_01_0_80000210
1_00000013_1_0_1_1_1_1_80000218_80000302_02_0_00000000_80000218_00000013_0_0_0_02_0_8000021c
// misaligned pc, access fault, error ignored while stalled
1_00000013_1_0_1_1_1_1_80000302_80000400_02_0_00000000_80000302_00000013_2_0_0_02_0_80000306
1_00000013_1_1_0_0_0_0_00000000_00000000_00_0_00000000_80000400_00000013_1_0_0_02_0_80000404
1_00000013_0_1_0_0_0_0_00000000_00000000_00_0_00000000_80000404_00000013_0_1_0_02_0_80000408
// same btb slot with another tag misses
1_00028067_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000404_00028067_0_0_0_02_0_80000408
1_00000013_1_0_0_0_0_0_00000000_00000000_00_0_00000000_80000408_00000013_0_0_0_02_0_8000040c

// File: fetch.f
fetch_pkg.sv
pc_reg.sv
gshare_pht.sv
branch_target_buffer.sv
return_addr_stack.sv
bpu.sv
ifu.sv
fetch_top.sv
tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary -f fetch.f --top-module tb_fetch_top -o tb_fetch_top_sim
./obj_dir/tb_fetch_top_sim

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

  localparam logic [fetch_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000;
  localparam int PHT_IDX_W    = 8;
  localparam int BTB_IDX_W    = 4;
  localparam int RAS_DEPTH    = 4;
  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 10;
  localparam int RESET_SLACK  = 20;
  localparam int MAX_LINES    = 64;

  // one cycle of the golden file with every field padded to whole hex digits
  typedef struct packed {
    logic [3:0]                    active;
    logic [fetch_pkg::XLEN-1:0]    rdata;
    logic [3:0]                    valid;
    logic [3:0]                    err;
    logic [3:0]                    ex_valid;
    logic [3:0]                    ex_kind;
    logic [3:0]                    ex_taken;
    logic [3:0]                    ex_mispredict;
    logic [fetch_pkg::XLEN-1:0]    ex_pc;
    logic [fetch_pkg::XLEN-1:0]    ex_target;
    logic [fetch_pkg::HIS_LEN-1:0] ex_history;
    logic [3:0]                    push;
    logic [fetch_pkg::XLEN-1:0]    push_data;
    logic [fetch_pkg::XLEN-1:0]    exp_pc;
    logic [fetch_pkg::XLEN-1:0]    exp_inst;
    logic [3:0]                    exp_trap;
    logic [3:0]                    exp_stall;
    logic [3:0]                    exp_taken;
    logic [fetch_pkg::HIS_LEN-1:0] exp_history;
    logic [3:0]                    exp_npc_valid;
    logic [fetch_pkg::XLEN-1:0]    exp_npc;
  } golden_line_t;

  logic                       clk = 1'b0;
  logic                       rst_n_i;
  logic [fetch_pkg::XLEN-1:0] imem_addr_o;
  logic [fetch_pkg::XLEN-1:0] imem_rdata_i;
  logic                       imem_valid_i;
  logic                       imem_err_i;
  fetch_pkg::ex_update_t      ex_update_i;
  logic                       ras_push_i;
  logic [fetch_pkg::XLEN-1:0] ras_push_data_i;
  fetch_pkg::fetch_out_t      fetch_o;
  logic                       stall_o;
  fetch_pkg::pred_meta_t      pred_o;
  logic [fetch_pkg::XLEN-1:0] next_pc_o;
  logic                       next_pc_valid_o;

  golden_line_t golden [MAX_LINES];
  int           line_idx;
  int           wait_cycles;

  fetch_top #(
    .RESET_PC  (RESET_PC),
    .PHT_IDX_W (PHT_IDX_W),
    .BTB_IDX_W (BTB_IDX_W),
    .RAS_DEPTH (RAS_DEPTH)
  ) fetch_top_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .imem_addr_o     (imem_addr_o),
    .imem_rdata_i    (imem_rdata_i),
    .imem_valid_i    (imem_valid_i),
    .imem_err_i      (imem_err_i),
    .ex_update_i     (ex_update_i),
    .ras_push_i      (ras_push_i),
    .ras_push_data_i (ras_push_data_i),
    .fetch_o         (fetch_o),
    .stall_o         (stall_o),
    .pred_o          (pred_o),
    .next_pc_o       (next_pc_o),
    .next_pc_valid_o (next_pc_valid_o)
  );

  // 100 ns clock
  always #HALF_PERIOD clk = ~clk;

  // reset low for the first cycles and released on a falling edge
  initial begin
    rst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_fetch(input fetch_pkg::fetch_out_t got, input fetch_pkg::fetch_out_t exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got pc %h inst %h trap %b, exp %h %h %b",
                          $time, what, got.pc, got.inst, got.trap, exp.pc, exp.inst, exp.trap));
    end
  endtask

  task automatic check_pred(input fetch_pkg::pred_meta_t got, input fetch_pkg::pred_meta_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got taken %b history %h, exp %b %h",
                          $time, what, got.pdt_taken, got.history, exp.pdt_taken, exp.history));
    end
  endtask

  task automatic check_pc(input logic [fetch_pkg::XLEN-1:0] got,
                          input logic [fetch_pkg::XLEN-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got %h, exp %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got %b, exp %b", $time, what, got, exp));
    end
  endtask

  // memory answer, EX record and ID push for one cycle
  task automatic apply_line(input golden_line_t vec);
    imem_rdata_i           = vec.rdata;
    imem_valid_i           = vec.valid[0];
    imem_err_i             = vec.err[0];
    ex_update_i.valid      = vec.ex_valid[0];
    ex_update_i.kind       = fetch_pkg::jump_kind_e'(vec.ex_kind[1:0]);
    ex_update_i.taken      = vec.ex_taken[0];
    ex_update_i.mispredict = vec.ex_mispredict[0];
    ex_update_i.pc         = vec.ex_pc;
    ex_update_i.target     = vec.ex_target;
    ex_update_i.history    = vec.ex_history;
    ras_push_i             = vec.push[0];
    ras_push_data_i        = vec.push_data;
  endtask

  task automatic compare_line(input golden_line_t vec, input int idx);
    fetch_pkg::fetch_out_t exp_fetch;
    fetch_pkg::pred_meta_t exp_pred;
    string                 tag;
    tag                                 = $sformatf("line %0d", idx);
    exp_fetch.pc                        = vec.exp_pc;
    exp_fetch.inst                      = vec.exp_inst;
    // trap digit is {misaligned, access fault}
    exp_fetch.trap.inst_addr_misaligned = vec.exp_trap[1];
    exp_fetch.trap.inst_access_fault    = vec.exp_trap[0];
    exp_pred.pdt_taken                  = vec.exp_taken[0];
    exp_pred.history                    = vec.exp_history;
    check_pc(imem_addr_o, vec.exp_pc, {tag, " imem_addr_o"});
    check_fetch(fetch_o, exp_fetch, {tag, " fetch_o"});
    check_bit(stall_o, vec.exp_stall[0], {tag, " stall_o"});
    check_pred(pred_o, exp_pred, {tag, " pred_o"});
    check_bit(next_pc_valid_o, vec.exp_npc_valid[0], {tag, " next_pc_valid_o"});
    check_pc(next_pc_o, vec.exp_npc, {tag, " next_pc_o"});
  endtask

  initial begin
    imem_rdata_i    = '0;
    imem_valid_i    = 1'b0;
    imem_err_i      = 1'b0;
    ex_update_i     = '0;
    ras_push_i      = 1'b0;
    ras_push_data_i = '0;
    // zero lines mark the end of the data
    for (int i = 0; i < MAX_LINES; i++) begin
      golden[i] = '0;
    end
    $readmemh("fetch_golden.txt", golden);

    wait_cycles = 0;
    while (rst_n_i !== 1'b1) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > RESET_CYCLES + RESET_SLACK) begin
        abort_run("reset was never released");
      end
    end

    // drive on the falling edge and sample shortly before the rising edge
    line_idx = 0;
    while (golden[line_idx].active == 4'h1) begin
      if (line_idx >= MAX_LINES - 1) begin
        abort_run("golden data did not end within the line limit");
      end
      @(negedge clk);
      apply_line(golden[line_idx]);
      #(HALF_PERIOD - 5);
      compare_line(golden[line_idx], line_idx);
      line_idx++;
    end

    if (line_idx > 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("golden file held no vectors");
    end
  end

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC  = 32'h8000_0000,
  parameter int                         PHT_IDX_W = 8,
  parameter int                         BTB_IDX_W = 4,
  parameter int                         RAS_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  // instruction memory
  output logic [fetch_pkg::XLEN-1:0] imem_addr_o,
  input  logic [fetch_pkg::XLEN-1:0] imem_rdata_i,
  input  logic                       imem_valid_i,
  input  logic                       imem_err_i,
  // resolution from EX
  input  fetch_pkg::ex_update_t      ex_update_i,
  // call return address from ID
  input  logic                       ras_push_i,
  input  logic [fetch_pkg::XLEN-1:0] ras_push_data_i,
  // toward IF/ID
  output fetch_pkg::fetch_out_t      fetch_o,
  output logic                       stall_o,
  output fetch_pkg::pred_meta_t      pred_o,
  output logic [fetch_pkg::XLEN-1:0] next_pc_o,
  output logic                       next_pc_valid_o
);

  // pc doubles as the memory address
  pc_reg #(
    .RESET_PC (RESET_PC)
  ) pc_reg_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_o),
    .pred_valid_i (next_pc_valid_o),
    .pred_pc_i    (next_pc_o),
    .ex_update_i  (ex_update_i),
    .pc_o         (imem_addr_o)
  );

  ifu ifu_inst (
    .pc_i          (imem_addr_o),
    .rdata_i       (imem_rdata_i),
    .rdata_valid_i (imem_valid_i),
    .rdata_err_i   (imem_err_i),
    .fetch_o       (fetch_o),
    .stall_o       (stall_o)
  );

  bpu #(
    .PHT_IDX_W (PHT_IDX_W),
    .BTB_IDX_W (BTB_IDX_W),
    .RAS_DEPTH (RAS_DEPTH)
  ) bpu_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .pc_i            (imem_addr_o),
    .inst_i          (imem_rdata_i),
    .stall_i         (stall_o),
    .ex_update_i     (ex_update_i),
    .ras_push_i      (ras_push_i),
    .ras_push_data_i (ras_push_data_i),
    .pred_valid_o    (next_pc_valid_o),
    .pred_pc_o       (next_pc_o),
    .pred_o          (pred_o)
  );

endmodule

// File: ifu.sv
`timescale 1ns/1ps

module ifu (
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  logic                       rdata_valid_i,
  input  logic                       rdata_err_i,
  output fetch_pkg::fetch_out_t      fetch_o,
  output logic                       stall_o
);

  fetch_pkg::trap_t trap;

  // pc must sit on a word boundary
  assign trap.inst_addr_misaligned = |pc_i[1:0];

  // bus error only counts with a valid answer
  assign trap.inst_access_fault = rdata_valid_i & rdata_err_i;

  // memory not ready yet so hold the front end
  assign stall_o = ~rdata_valid_i;

  // record for IF/ID
  assign fetch_o.pc   = pc_i;
  assign fetch_o.inst = rdata_i;
  assign fetch_o.trap = trap;

endmodule

// File: bpu.sv
`timescale 1ns/1ps

module bpu #(
  parameter int PHT_IDX_W = 8,
  parameter int BTB_IDX_W = 4,
  parameter int RAS_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  logic [fetch_pkg::XLEN-1:0] inst_i,
  input  logic                       stall_i,
  input  fetch_pkg::ex_update_t      ex_update_i,
  input  logic                       ras_push_i,
  input  logic [fetch_pkg::XLEN-1:0] ras_push_data_i,
  output logic                       pred_valid_o,
  output logic [fetch_pkg::XLEN-1:0] pred_pc_o,
  output fetch_pkg::pred_meta_t      pred_o
);

  logic [6:0]                    opcode;
  logic [4:0]                    rd;
  logic [4:0]                    rs1;
  logic [fetch_pkg::XLEN-1:0]    imm_j;
  logic [fetch_pkg::XLEN-1:0]    imm_b;
  logic [fetch_pkg::XLEN-1:0]    seq_pc;
  logic                          is_ret;
  logic                          redirect;
  logic                          ras_pop;
  logic                          pht_taken;
  logic [fetch_pkg::HIS_LEN-1:0] history;
  logic                          btb_hit;
  logic [fetch_pkg::XLEN-1:0]    btb_target;
  logic                          ras_empty;
  logic [fetch_pkg::XLEN-1:0]    ras_top;

  // field pre-decode
  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign rs1    = inst_i[19:15];

  // sign-extended jal and branch offsets
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  assign seq_pc = pc_i + 32'd4;

  // jalr x0, 0(ra) is a return
  assign is_ret = (opcode == fetch_pkg::OPC_JALR) && (rs1 == fetch_pkg::REG_RA) && (rd == '0);

  assign redirect = ex_update_i.valid & ex_update_i.mispredict;
  // only consume the entry when the fetch actually moves on
  assign ras_pop  = is_ret && !ras_empty && !stall_i && !redirect;

  always_comb begin
    pred_valid_o = 1'b0;
    pred_pc_o    = seq_pc;
    case (opcode)
      fetch_pkg::OPC_JAL: begin
        pred_valid_o = 1'b1;
        pred_pc_o    = pc_i + imm_j;
      end
      fetch_pkg::OPC_BRANCH: begin
        pred_valid_o = pht_taken;
        if (pht_taken) begin
          pred_pc_o = pc_i + imm_b;
        end
      end
      fetch_pkg::OPC_JALR: begin
        // ras first for returns and btb as fallback
        if (is_ret && !ras_empty) begin
          pred_valid_o = 1'b1;
          pred_pc_o    = ras_top;
        end else if (btb_hit) begin
          pred_valid_o = 1'b1;
          pred_pc_o    = btb_target;
        end
      end
      default: begin
      end
    endcase
  end

  assign pred_o.pdt_taken = pred_valid_o;
  assign pred_o.history   = history;

  gshare_pht #(
    .PHT_IDX_W (PHT_IDX_W)
  ) gshare_pht_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pc_i        (pc_i),
    .ex_update_i (ex_update_i),
    .taken_o     (pht_taken),
    .history_o   (history)
  );

  branch_target_buffer #(
    .BTB_IDX_W (BTB_IDX_W)
  ) branch_target_buffer_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pc_i        (pc_i),
    .ex_update_i (ex_update_i),
    .hit_o       (btb_hit),
    .target_o    (btb_target)
  );

  return_addr_stack #(
    .RAS_DEPTH (RAS_DEPTH)
  ) return_addr_stack_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .push_i      (ras_push_i),
    .push_data_i (ras_push_data_i),
    .pop_i       (ras_pop),
    .empty_o     (ras_empty),
    .top_o       (ras_top)
  );

endmodule

// File: return_addr_stack.sv
`timescale 1ns/1ps

module return_addr_stack #(
  parameter int RAS_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       push_i,
  input  logic [fetch_pkg::XLEN-1:0] push_data_i,
  input  logic                       pop_i,
  output logic                       empty_o,
  output logic [fetch_pkg::XLEN-1:0] top_o
);

  localparam int PTR_W = $clog2(RAS_DEPTH);
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);

  logic [fetch_pkg::XLEN-1:0] stack_q [RAS_DEPTH];
  // points at the current top entry
  logic [PTR_W-1:0]           top_q;
  logic [CNT_W-1:0]           count_q;
  logic [PTR_W-1:0]           ptr_inc;
  logic [PTR_W-1:0]           ptr_dec;
  logic                       do_pop;
  logic                       full;

  // wrap by hand since depth need not be a power of two
  assign ptr_inc = (top_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : top_q + 1'b1;
  assign ptr_dec = (top_q == '0) ? PTR_W'(RAS_DEPTH - 1) : top_q - 1'b1;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == CNT_W'(RAS_DEPTH));
  // pop on empty is dropped
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (push_i && !do_pop) begin
      top_q <= ptr_inc;
      // when full the oldest slot is reused and count stays
      if (!full) begin
        count_q <= count_q + 1'b1;
      end
    end else if (do_pop && !push_i) begin
      top_q   <= ptr_dec;
      count_q <= count_q - 1'b1;
    end
  end

  // push with pop swaps the top in place
  always_ff @(posedge clk) begin
    if (push_i) begin
      if (do_pop) begin
        stack_q[top_q] <= push_data_i;
      end else begin
        stack_q[ptr_inc] <= push_data_i;
      end
    end
  end

  assign top_o = stack_q[top_q];

endmodule

// File: branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer #(
  parameter int BTB_IDX_W = 4
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  fetch_pkg::ex_update_t      ex_update_i,
  output logic                       hit_o,
  output logic [fetch_pkg::XLEN-1:0] target_o
);

  localparam int BTB_SIZE = 1 << BTB_IDX_W;
  // pc bits left above the index
  localparam int TAG_W = fetch_pkg::XLEN - BTB_IDX_W - 2;

  typedef struct packed {
    logic [TAG_W-1:0]           tag;
    logic [fetch_pkg::XLEN-1:0] target;
  } btb_entry_t;

  logic [BTB_SIZE-1:0]  valid_q;
  btb_entry_t           entry_q [BTB_SIZE];
  logic [BTB_IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0]     rd_tag;
  logic [BTB_IDX_W-1:0] wr_idx;
  logic                 wr_en;
  btb_entry_t           rd_entry;
  btb_entry_t           wr_entry;

  // fetch side lookup
  assign rd_idx   = pc_i[BTB_IDX_W+1:2];
  assign rd_tag   = pc_i[fetch_pkg::XLEN-1:BTB_IDX_W+2];
  assign rd_entry = entry_q[rd_idx];

  // resolved jalr fills its slot
  assign wr_en           = ex_update_i.valid && (ex_update_i.kind == fetch_pkg::JUMP_JALR);
  assign wr_idx          = ex_update_i.pc[BTB_IDX_W+1:2];
  assign wr_entry.tag    = ex_update_i.pc[fetch_pkg::XLEN-1:BTB_IDX_W+2];
  assign wr_entry.target = ex_update_i.target;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // payload array
  always_ff @(posedge clk) begin
    if (wr_en) begin
      entry_q[wr_idx] <= wr_entry;
    end
  end

  assign hit_o    = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
  assign target_o = rd_entry.target;

endmodule

// File: gshare_pht.sv
`timescale 1ns/1ps

module gshare_pht #(
  parameter int PHT_IDX_W = 8
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0]    pc_i,
  input  fetch_pkg::ex_update_t         ex_update_i,
  output logic                          taken_o,
  output logic [fetch_pkg::HIS_LEN-1:0] history_o
);

  localparam int PHT_SIZE = 1 << PHT_IDX_W;

  // two-bit saturating counters
  logic [1:0]                    cnt_q [PHT_SIZE];
  // global history with the newest outcome in bit 0
  logic [fetch_pkg::HIS_LEN-1:0] ghr_q;
  logic [PHT_IDX_W-1:0]          rd_idx;
  logic [PHT_IDX_W-1:0]          wr_idx;
  logic                          train;
  logic [1:0]                    wr_cnt;

  // fetch lookup hashes with the live history
  assign rd_idx = pc_i[PHT_IDX_W+1:2] ^ PHT_IDX_W'(ghr_q);

  // training reuses the history seen at prediction time
  assign wr_idx = ex_update_i.pc[PHT_IDX_W+1:2] ^ PHT_IDX_W'(ex_update_i.history);

  assign train = ex_update_i.valid && (ex_update_i.kind == fetch_pkg::JUMP_BRANCH);
  assign wr_cnt = cnt_q[wr_idx];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ghr_q <= '0;
      // weakly not taken
      for (int i = 0; i < PHT_SIZE; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (train) begin
      ghr_q <= {ghr_q[fetch_pkg::HIS_LEN-2:0], ex_update_i.taken};
      // saturate at 3 and 0
      if (ex_update_i.taken && (wr_cnt != 2'b11)) begin
        cnt_q[wr_idx] <= wr_cnt + 2'd1;
      end else if (!ex_update_i.taken && (wr_cnt != 2'b00)) begin
        cnt_q[wr_idx] <= wr_cnt - 2'd1;
      end
    end
  end

  // upper counter bit is the direction
  assign taken_o   = cnt_q[rd_idx][1];
  assign history_o = ghr_q;

endmodule

// File: pc_reg.sv
`timescale 1ns/1ps

module pc_reg #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        stall_i,
  input  logic                        pred_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]  pred_pc_i,
  input  fetch_pkg::ex_update_t       ex_update_i,
  output logic [fetch_pkg::XLEN-1:0]  pc_o
);

  logic [fetch_pkg::XLEN-1:0] pc_q;
  logic [fetch_pkg::XLEN-1:0] pc_d;
  logic [fetch_pkg::XLEN-1:0] resolved_pc;
  logic                       redirect;

  // EX found a wrong guess
  assign redirect = ex_update_i.valid & ex_update_i.mispredict;

  // where the mispredicted instruction really goes
  assign resolved_pc = ex_update_i.taken ? ex_update_i.target : ex_update_i.pc + 32'd4;

  // redirect beats stall so a flush is never dropped
  always_comb begin
    if (redirect) begin
      pc_d = resolved_pc;
    end else if (stall_i) begin
      pc_d = pc_q;
    end else if (pred_valid_i) begin
      pc_d = pred_pc_i;
    end else begin
      pc_d = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

  // machine width for data and addresses
  localparam int XLEN = 32;

  // global history length shared by the history fields
  localparam int HIS_LEN = 8;

  // rv32i control-flow opcodes
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // link register used to spot calls and returns
  localparam logic [4:0] REG_RA = 5'd1;

  // jump type as resolved in EX
  typedef enum logic [1:0] {
    JUMP_NONE   = 2'b00,
    JUMP_JAL    = 2'b01,
    JUMP_JALR   = 2'b10,
    JUMP_BRANCH = 2'b11
  } jump_kind_e;

  // fetch-stage exceptions
  typedef struct packed {
    logic inst_addr_misaligned;
    logic inst_access_fault;
  } trap_t;

  // record handed to IF/ID
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    trap_t           trap;
  } fetch_out_t;

  // resolution record coming back from EX
  typedef struct packed {
    logic               valid;
    jump_kind_e         kind;
    logic               taken;
    logic               mispredict;
    logic [XLEN-1:0]    pc;
    logic [XLEN-1:0]    target;
    logic [HIS_LEN-1:0] history;
  } ex_update_t;

  // prediction side info carried down to EX
  typedef struct packed {
    logic               pdt_taken;
    logic [HIS_LEN-1:0] history;
  } pred_meta_t;

endpackage
